//--- Bender.yml
package:
  name: cache

export_include_dirs:
  - include

sources:
  - hdl/cache_pkg.sv
  - hdl/cache_dma_pkg.sv
  - hdl/cache_dma_if.sv
  - hdl/cache_lookup.sv
  - hdl/cache_verify.sv
  - hdl/cache_miss.sv
  - hdl/cache_dma.sv
  - hdl/cache_top.sv
  - target: test
    files:
      - bench/cache_tb.sv

//--- bench/cache_tb.sv
// cache testbench
// replays a request trace against a block memory model with random handshake delays

`default_nettype none

`include "cache_macros.svh"

module cache_tb;

  localparam int TRACE_WORDS = 256;
  localparam int MEM_WORDS = 1 << (`CACHE_ADDR_WIDTH - 2);
  localparam int TIMEOUT = 2000;

  typedef struct packed {
    cache_pkg::cache_op_e op;
    cache_pkg::addr_t addr;
    cache_pkg::data_t data;
    cache_pkg::data_t resp;
  } pend_t;

  logic clk_i = 1'b0;
  logic reset_i;
  logic req_v_i;
  cache_pkg::cache_op_e req_op_i;
  cache_pkg::addr_t req_addr_i;
  cache_pkg::data_t req_data_i;
  logic ready_o;
  logic resp_v_o;
  cache_pkg::data_t resp_data_o;
  logic resp_yumi_i;
  logic dma_pkt_v_o;
  logic dma_pkt_write_o;
  cache_dma_pkg::block_addr_t dma_pkt_addr_o;
  logic dma_pkt_yumi_i;
  cache_pkg::data_t dma_rdata_i;
  logic dma_rdata_v_i;
  logic dma_rdata_ready_o;
  cache_pkg::data_t dma_wdata_o;
  logic dma_wdata_v_o;
  logic dma_wdata_yumi_i;

  logic [31:0] trace_mem [TRACE_WORDS];
  cache_pkg::data_t mem [MEM_WORDS];
  cache_pkg::data_t exp_mem [MEM_WORDS];
  pend_t pend_q [$];
  logic [15:0] lfsr = 16'd8860;
  logic timed_out = 1'b0;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int fill_pkts = 0;
  int wb_pkts = 0;
  int err_mark;
  int fill_mark;
  int wb_mark;
  int fill_base;
  int fill_idx;
  int wb_base;
  int wb_idx;

  cache_top uut (.*);

  always #10 clk_i = ~clk_i;

  // galois LFSR stepped once per bit taken
  function automatic logic random_bit();
    logic out;
    out = lfsr[0];
    lfsr = (lfsr >> 1) ^ (out ? 16'hB400 : 16'h0000);
    return out;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("Mismatch %s: got %h, expected %h", name, got, want);
      errors++;
    end
  endtask

  task automatic send_request(input int rec);
    int waited;
    pend_t item;
    item.op = cache_pkg::cache_op_e'(trace_mem[4 * rec][2:0]);
    item.addr = trace_mem[4 * rec + 1][15:0];
    item.data = trace_mem[4 * rec + 2];
    item.resp = trace_mem[4 * rec + 3];
    req_v_i <= 1'b1;
    req_op_i <= item.op;
    req_addr_i <= item.addr;
    req_data_i <= item.data;
    waited = 0;
    @(posedge clk_i);
    while (!ready_o && waited < TIMEOUT) begin
      waited++;
      @(posedge clk_i);
    end
    if (ready_o) begin
      pend_q.push_back(item);
    end else begin
      $display("Timeout: request %0d at address %h was never accepted", rec, item.addr);
      timed_out = 1'b1;
    end
  endtask

  // drain all responses, then compare packet counts for the test
  task automatic finish_test(input int rec);
    int waited;
    int test_id;
    test_id = trace_mem[4 * rec + 1];
    req_v_i <= 1'b0;
    waited = 0;
    @(negedge clk_i);
    while (pend_q.size() != 0 && waited < TIMEOUT) begin
      waited++;
      @(negedge clk_i);
    end
    if (pend_q.size() != 0) begin
      $display("Timeout: test %0d still waits for %0d responses", test_id, pend_q.size());
      timed_out = 1'b1;
    end else begin
      check_value("fill packet count", fill_pkts - fill_mark, trace_mem[4 * rec + 2]);
      check_value("write-back packet count", wb_pkts - wb_mark, trace_mem[4 * rec + 3]);
      tests_run++;
      if (errors != err_mark) begin
        tests_failed++;
      end
      $display("test %0d: %s, %0d errors", test_id,
        (errors == err_mark) ? "passed" : "failed", errors - err_mark);
      err_mark = errors;
      fill_mark = fill_pkts;
      wb_mark = wb_pkts;
      @(posedge clk_i);
    end
  endtask

  always @(posedge clk_i) begin : memory_model
    pend_t head;
    if (reset_i) begin
      resp_yumi_i <= 1'b0;
      dma_pkt_yumi_i <= 1'b0;
      dma_rdata_v_i <= 1'b0;
      dma_wdata_yumi_i <= 1'b0;
      fill_idx = 4;
      wb_idx = 4;
    end else begin
      if (resp_v_o && resp_yumi_i) begin
        resp_yumi_i <= 1'b0;
        if (pend_q.size() == 0) begin
          $display("A response arrived with no request outstanding");
          errors++;
        end else begin
          head = pend_q.pop_front();
          check_value("resp_data_o", resp_data_o, head.resp);
          if (head.op == cache_pkg::OP_SW) begin
            exp_mem[head.addr[15:2]] = head.data;
          end else if (head.op == cache_pkg::OP_SB) begin
            exp_mem[head.addr[15:2]][8 * head.addr[1:0] +: 8] = head.data[7:0];
          end
        end
      end else begin
        resp_yumi_i <= resp_v_o ? random_bit() : 1'b0;
      end
      // the request in verify owns the packet
      if (dma_pkt_v_o && dma_pkt_yumi_i) begin
        dma_pkt_yumi_i <= 1'b0;
        if (pend_q.size() == 0) begin
          $display("A memory packet arrived with no request outstanding");
          errors++;
        end else if (dma_pkt_write_o) begin
          check_value("dma_pkt_addr_o index", dma_pkt_addr_o[3:0], pend_q[0].addr[7:4]);
          wb_base = int'(dma_pkt_addr_o) * 4;
          wb_idx = 0;
          wb_pkts++;
        end else begin
          check_value("dma_pkt_addr_o", dma_pkt_addr_o, pend_q[0].addr[15:4]);
          fill_base = int'(dma_pkt_addr_o) * 4;
          fill_idx = 0;
          fill_pkts++;
        end
      end else begin
        dma_pkt_yumi_i <= dma_pkt_v_o ? random_bit() : 1'b0;
      end
      if (dma_rdata_v_i && dma_rdata_ready_o) begin
        fill_idx++;
      end
      if (fill_idx < 4 && random_bit()) begin
        dma_rdata_v_i <= 1'b1;
        dma_rdata_i <= mem[fill_base + fill_idx];
      end else begin
        dma_rdata_v_i <= 1'b0;
      end
      if (dma_wdata_v_o && dma_wdata_yumi_i) begin
        dma_wdata_yumi_i <= 1'b0;
        if (wb_idx < 4) begin
          check_value("dma_wdata_o", dma_wdata_o, exp_mem[wb_base + wb_idx]);
          mem[wb_base + wb_idx] = dma_wdata_o;
          wb_idx++;
        end else begin
          $display("Write-back data arrived without a write-back packet");
          errors++;
        end
      end else begin
        dma_wdata_yumi_i <= dma_wdata_v_o ? random_bit() : 1'b0;
      end
    end
  end

  initial begin : driver
    int rec;
    reset_i = 1'b1;
    req_v_i = 1'b0;
    req_op_i = cache_pkg::OP_LW;
    req_addr_i = '0;
    req_data_i = '0;
    resp_yumi_i = 1'b0;
    dma_pkt_yumi_i = 1'b0;
    dma_rdata_i = '0;
    dma_rdata_v_i = 1'b0;
    dma_wdata_yumi_i = 1'b0;
    // each word holds its byte address in both halves
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {2{16'(i * 4)}};
      exp_mem[i] = mem[i];
    end
    $readmemh("bench/cache_trace.txt", trace_mem);
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    check_value("ready_o", ready_o, 1'b1);
    check_value("resp_v_o", resp_v_o, 1'b0);
    check_value("dma_pkt_v_o", dma_pkt_v_o, 1'b0);
    check_value("dma_wdata_v_o", dma_wdata_v_o, 1'b0);
    check_value("dma_rdata_ready_o", dma_rdata_ready_o, 1'b0);
    err_mark = errors;
    fill_mark = fill_pkts;
    wb_mark = wb_pkts;
    rec = 0;
    while (rec < TRACE_WORDS / 4 && trace_mem[4 * rec] < 32'h6 && !timed_out) begin
      if (trace_mem[4 * rec] == 32'h5) begin
        finish_test(rec);
      end else begin
        send_request(rec);
      end
      rec++;
    end
    req_v_i <= 1'b0;
    if (tests_run == 0) begin
      $display("No complete test was read from the trace file");
      errors++;
    end
    $display("%0d tests run, %0d passed, %0d failed, %0d errors",
      tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/cache_trace.txt
// columns: op addr store_data expected_resp (op 0 lw, 1 sw, 2 lb, 3 lbu, 4 sb)
// op 5 ends a test: addr is the test id, then fill and write-back packet counts; op 6 ends
// cold load misses, then hits in the same block
0 0100 00000000 01000100
0 0104 00000000 01040104
3 010E 00000000 0000000C
5 0001 00000001 00000000
// word store then load, no packet
1 0108 CAFEF00D 00000000
0 0108 00000000 CAFEF00D
5 0002 00000000 00000000
// byte store with signed and unsigned byte loads
4 0105 000000A5 00000000
2 0105 00000000 FFFFFFA5
3 0105 00000000 000000A5
0 0104 00000000 0104A504
3 0104 00000000 00000004
2 0107 00000000 00000001
5 0003 00000000 00000000
// three blocks in set 3, dirty victim written back and reloaded
1 0234 11223344 00000000
0 0530 00000000 05300530
0 0830 00000000 08300830
0 0234 00000000 11223344
2 0237 00000000 00000011
5 0004 00000004 00000001
// mixed burst under random response back-pressure
0 0100 00000000 01000100
4 0102 0000007E 00000000
3 0102 00000000 0000007E
0 0100 00000000 017E0100
0 0C40 00000000 0C400C40
2 0C43 00000000 0000000C
1 0C4C 89ABCDEF 00000000
2 0C4C 00000000 FFFFFFEF
0 0108 00000000 CAFEF00D
0 1100 00000000 11001100
0 2100 00000000 21002100
0 0104 00000000 0104A504
5 0005 00000004 00000001
6 0000 00000000 00000000

//--- cache.f
+incdir+include
hdl/cache_pkg.sv
hdl/cache_dma_pkg.sv
hdl/cache_dma_if.sv
hdl/cache_lookup.sv
hdl/cache_verify.sv
hdl/cache_miss.sv
hdl/cache_dma.sv
hdl/cache_top.sv
bench/cache_tb.sv

//--- hdl/cache_dma.sv
// cache DMA engine
// sends one packet then moves a four word block into or out of the data array

`default_nettype none

`include "cache_macros.svh"

module cache_dma (
  input  logic clk_i,
  input  logic reset_i,
  cache_dma_if.dma cmd,
  input  cache_pkg::offset_t offset_i,
  output logic dma_pkt_v_o,
  output logic dma_pkt_write_o,
  output cache_dma_pkg::block_addr_t dma_pkt_addr_o,
  input  logic dma_pkt_yumi_i,
  input  cache_pkg::data_t dma_rdata_i,
  input  logic dma_rdata_v_i,
  output logic dma_rdata_ready_o,
  output cache_pkg::data_t dma_wdata_o,
  output logic dma_wdata_v_o,
  input  logic dma_wdata_yumi_i,
  output logic dma_mem_v_o,
  output logic dma_mem_we_o,
  output logic dma_mem_way_o,
  output logic [$bits(cache_pkg::index_t)+$bits(cache_pkg::offset_t)-1:0] dma_mem_addr_o,
  output cache_pkg::data_t dma_mem_wdata_o,
  input  cache_pkg::data_t dma_mem_rdata_i
);

  cache_dma_pkg::dma_state_e state_r;
  cache_pkg::offset_t cnt_r;
  logic rd_pend_r;
  logic wv_r;
  logic xfer;
  logic fill_beat;
  logic rd_issue;
  logic last;

  assign xfer = (state_r == cache_dma_pkg::DMA_XFER);
  assign last = (cnt_r == cache_pkg::offset_t'(`CACHE_BLOCK_WORDS-1));

  assign dma_pkt_v_o = (state_r == cache_dma_pkg::DMA_SEND_PKT);
  assign dma_rdata_ready_o = xfer & ~dma_pkt_write_o;
  assign fill_beat = dma_rdata_ready_o & dma_rdata_v_i;

  // evict reads one word ahead of the memory side
  assign rd_issue = xfer & dma_pkt_write_o & ~wv_r & ~rd_pend_r;
  assign dma_wdata_v_o = wv_r;
  assign dma_wdata_o = dma_mem_rdata_i;

  assign dma_mem_v_o = fill_beat | rd_issue;
  assign dma_mem_we_o = fill_beat;
  assign dma_mem_way_o = cmd.way;
  assign dma_mem_addr_o = {dma_pkt_addr_o[$bits(cache_pkg::index_t)-1:0], cnt_r};
  assign dma_mem_wdata_o = dma_rdata_i;

  assign cmd.done = (state_r == cache_dma_pkg::DMA_DONE);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= cache_dma_pkg::DMA_IDLE;
      cnt_r <= '0;
      rd_pend_r <= 1'b0;
      wv_r <= 1'b0;
    end else begin
      rd_pend_r <= rd_issue;
      wv_r <= (wv_r & ~dma_wdata_yumi_i) | rd_pend_r;
      case (state_r)
        cache_dma_pkg::DMA_IDLE: begin
          cnt_r <= '0;
          if (cmd.start) begin
            state_r <= cache_dma_pkg::DMA_SEND_PKT;
          end
        end
        cache_dma_pkg::DMA_SEND_PKT: begin
          if (dma_pkt_yumi_i) begin
            state_r <= cache_dma_pkg::DMA_XFER;
          end
        end
        cache_dma_pkg::DMA_XFER: begin
          if (fill_beat || (wv_r && dma_wdata_yumi_i)) begin
            cnt_r <= cnt_r + 1'b1;
            if (last) begin
              state_r <= cache_dma_pkg::DMA_DONE;
            end
          end
        end
        default: state_r <= cache_dma_pkg::DMA_IDLE;
      endcase
    end
  end

  // command latched at start, requested word caught during refill
  always_ff @(posedge clk_i) begin
    if (cmd.start && state_r == cache_dma_pkg::DMA_IDLE) begin
      dma_pkt_write_o <= cmd.write;
      dma_pkt_addr_o <= cmd.block_addr;
    end
    if (fill_beat && cnt_r == offset_i) begin
      cmd.fill_word <= dma_rdata_i;
    end
  end

endmodule

`default_nettype wire

//--- hdl/cache_dma_if.sv
// miss handler to DMA engine command channel

`default_nettype none

`include "cache_macros.svh"

interface cache_dma_if;

  logic start;
  logic write;
  cache_dma_pkg::block_addr_t block_addr;
  logic way;
  logic done;
  logic [`CACHE_DATA_WIDTH-1:0] fill_word;

  modport miss (output start, write, block_addr, way, input done, fill_word);
  modport dma (input start, write, block_addr, way, output done, fill_word);

endinterface

`default_nettype wire

//--- hdl/cache_dma_pkg.sv
// cache memory-side types
// block address and miss/DMA state encodings

`default_nettype none

`include "cache_macros.svh"

package cache_dma_pkg;

  // tag and index together
  typedef logic [`CACHE_ADDR_WIDTH-2-$clog2(`CACHE_BLOCK_WORDS)-1:0] block_addr_t;

  typedef enum logic [1:0] {MISS_IDLE, MISS_EVICT, MISS_FILL, MISS_DONE} miss_state_e;

  typedef enum logic [1:0] {DMA_IDLE, DMA_SEND_PKT, DMA_XFER, DMA_DONE} dma_state_e;

endpackage

`default_nettype wire

//--- hdl/cache_lookup.sv
// cache tag lookup stage
// holds tag, valid and data arrays and registers the accepted request

`default_nettype none

`include "cache_macros.svh"

module cache_lookup (
  input  logic clk_i,
  input  logic reset_i,
  input  logic req_v_i,
  input  cache_pkg::cache_op_e req_op_i,
  input  cache_pkg::addr_t req_addr_i,
  input  cache_pkg::data_t req_data_i,
  output logic ready_o,
  input  logic advance_i,
  output logic tl_v_o,
  output cache_pkg::cache_op_e tl_op_o,
  output cache_pkg::addr_t tl_addr_o,
  output cache_pkg::data_t tl_data_o,
  output cache_pkg::tag_t [1:0] tag_rd_o,
  output logic [1:0] valid_rd_o,
  output cache_pkg::data_t [1:0] line_rd_o,
  input  logic st_we_i,
  input  logic st_way_i,
  input  cache_pkg::addr_t st_addr_i,
  input  cache_pkg::byte_mask_t st_mask_i,
  input  cache_pkg::data_t st_data_i,
  input  logic tag_we_i,
  input  logic tag_way_i,
  input  cache_pkg::index_t tag_index_i,
  input  cache_pkg::tag_t tag_i,
  input  logic dma_mem_v_i,
  input  logic dma_mem_we_i,
  input  logic dma_mem_way_i,
  input  logic [$bits(cache_pkg::index_t)+$bits(cache_pkg::offset_t)-1:0] dma_mem_addr_i,
  input  cache_pkg::data_t dma_mem_wdata_i,
  output cache_pkg::data_t dma_mem_rdata_o
);

  cache_pkg::tag_t tag_mem [2][`CACHE_SETS];
  logic [`CACHE_SETS-1:0] valid_mem [2];
  cache_pkg::data_t data_mem [2][`CACHE_SETS*`CACHE_BLOCK_WORDS];

  cache_pkg::index_t tl_index;
  cache_pkg::offset_t tl_offset;
  logic accept;

  // DMA has the port first, then the store, new requests last
  assign ready_o = advance_i & ~dma_mem_v_i & ~st_we_i;
  assign accept = req_v_i & ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tl_v_o <= 1'b0;
    end else if (advance_i) begin
      tl_v_o <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      tl_op_o <= req_op_i;
      tl_addr_o <= req_addr_i;
      tl_data_o <= req_data_i;
    end
  end

  assign tl_offset = tl_addr_o[2 +: $bits(cache_pkg::offset_t)];
  assign tl_index = tl_addr_o[4 +: $bits(cache_pkg::index_t)];

  // array reads follow the held request so refills and stores are seen
  for (genvar w = 0; w < 2; w++) begin : g_way
    assign tag_rd_o[w] = tag_mem[w][tl_index];
    assign valid_rd_o[w] = valid_mem[w][tl_index];
    assign line_rd_o[w] = data_mem[w][{tl_index, tl_offset}];
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_mem[0] <= '0;
      valid_mem[1] <= '0;
    end else if (tag_we_i) begin
      valid_mem[tag_way_i][tag_index_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tag_we_i) begin
      tag_mem[tag_way_i][tag_index_i] <= tag_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dma_mem_v_i) begin
      if (dma_mem_we_i) begin
        data_mem[dma_mem_way_i][dma_mem_addr_i] <= dma_mem_wdata_i;
      end else begin
        dma_mem_rdata_o <= data_mem[dma_mem_way_i][dma_mem_addr_i];
      end
    end else if (st_we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (st_mask_i[b]) begin
          data_mem[st_way_i][st_addr_i[7:2]][8*b +: 8] <= st_data_i[8*b +: 8];
        end
      end
    end
  end

  // store writes come only from a retired hit, never mid-transfer
  assert property (@(posedge clk_i) disable iff (reset_i)
    !(dma_mem_v_i && dma_mem_we_i && st_we_i));

endmodule

`default_nettype wire

//--- hdl/cache_miss.sv
// cache miss handler
// evicts a dirty victim, refills the block and installs the new tag

`default_nettype none

module cache_miss (
  input  logic clk_i,
  input  logic reset_i,
  input  logic miss_i,
  input  logic miss_way_i,
  input  logic miss_dirty_i,
  input  cache_pkg::tag_t victim_tag_i,
  input  cache_pkg::addr_t miss_addr_i,
  output logic tag_we_o,
  output logic tag_way_o,
  output cache_pkg::index_t tag_index_o,
  output cache_pkg::tag_t tag_o,
  output logic miss_done_o,
  cache_dma_if.miss dma
);

  cache_dma_pkg::miss_state_e state_r;
  logic evicted_r;
  cache_pkg::index_t index;

  assign index = miss_addr_i[4 +: $bits(cache_pkg::index_t)];

  // evict first when needed and refill from idle on the way back
  assign dma.start = (state_r == cache_dma_pkg::MISS_IDLE) & miss_i;
  assign dma.write = miss_dirty_i & ~evicted_r;
  assign dma.block_addr = dma.write ? {victim_tag_i, index} : miss_addr_i[15:4];
  assign dma.way = miss_way_i;

  assign tag_we_o = (state_r == cache_dma_pkg::MISS_DONE);
  assign tag_way_o = miss_way_i;
  assign tag_index_o = index;
  assign tag_o = miss_addr_i[15:8];
  assign miss_done_o = tag_we_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= cache_dma_pkg::MISS_IDLE;
      evicted_r <= 1'b0;
    end else begin
      case (state_r)
        cache_dma_pkg::MISS_IDLE: begin
          if (dma.start) begin
            state_r <= dma.write ? cache_dma_pkg::MISS_EVICT : cache_dma_pkg::MISS_FILL;
          end
        end
        cache_dma_pkg::MISS_EVICT: begin
          if (dma.done) begin
            evicted_r <= 1'b1;
            state_r <= cache_dma_pkg::MISS_IDLE;
          end
        end
        cache_dma_pkg::MISS_FILL: begin
          if (dma.done) begin
            evicted_r <= 1'b0;
            state_r <= cache_dma_pkg::MISS_DONE;
          end
        end
        default: state_r <= cache_dma_pkg::MISS_IDLE;
      endcase
    end
  end

  // done answers only a transfer this handler started
  assert property (@(posedge clk_i) disable iff (reset_i)
    dma.done |-> (state_r == cache_dma_pkg::MISS_EVICT ||
                  state_r == cache_dma_pkg::MISS_FILL));

endmodule

`default_nettype wire

//--- hdl/cache_pkg.sv
// cache request-side types
// address fields, data word and opcodes

`default_nettype none

`include "cache_macros.svh"

package cache_pkg;

  typedef logic [`CACHE_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`CACHE_DATA_WIDTH-1:0] data_t;
  typedef logic [$clog2(`CACHE_BLOCK_WORDS)-1:0] offset_t;
  typedef logic [$clog2(`CACHE_SETS)-1:0] index_t;
  typedef logic [`CACHE_ADDR_WIDTH-2-$bits(offset_t)-$bits(index_t)-1:0] tag_t;
  typedef logic [`CACHE_DATA_WIDTH/8-1:0] byte_mask_t;

  typedef enum logic [2:0] {
    OP_LW  = 3'd0,
    OP_SW  = 3'd1,
    OP_LB  = 3'd2,
    OP_LBU = 3'd3,
    OP_SB  = 3'd4
  } cache_op_e;

endpackage

`default_nettype wire

//--- hdl/cache_top.sv
// two-way write-back data cache
// lookup and verify pipeline with miss handler and DMA engine

`default_nettype none

module cache_top (
  input  logic clk_i,
  input  logic reset_i,
  input  logic req_v_i,
  input  cache_pkg::cache_op_e req_op_i,
  input  cache_pkg::addr_t req_addr_i,
  input  cache_pkg::data_t req_data_i,
  output logic ready_o,
  output logic resp_v_o,
  output cache_pkg::data_t resp_data_o,
  input  logic resp_yumi_i,
  output logic dma_pkt_v_o,
  output logic dma_pkt_write_o,
  output cache_dma_pkg::block_addr_t dma_pkt_addr_o,
  input  logic dma_pkt_yumi_i,
  input  cache_pkg::data_t dma_rdata_i,
  input  logic dma_rdata_v_i,
  output logic dma_rdata_ready_o,
  output cache_pkg::data_t dma_wdata_o,
  output logic dma_wdata_v_o,
  input  logic dma_wdata_yumi_i
);

  logic advance, tl_v;
  cache_pkg::cache_op_e tl_op;
  cache_pkg::addr_t tl_addr;
  cache_pkg::data_t tl_data;
  cache_pkg::tag_t [1:0] tag_rd;
  logic [1:0] valid_rd;
  cache_pkg::data_t [1:0] line_rd;
  logic miss, miss_way, miss_dirty, miss_done;
  cache_pkg::tag_t victim_tag, tag_new;
  cache_pkg::addr_t miss_addr;
  logic st_we, st_way;
  cache_pkg::byte_mask_t st_mask;
  cache_pkg::data_t st_data;
  logic tag_we, tag_way;
  cache_pkg::index_t tag_index;
  logic mem_v, mem_we, mem_way;
  logic [$bits(cache_pkg::index_t)+$bits(cache_pkg::offset_t)-1:0] mem_addr;
  cache_pkg::data_t mem_wdata, mem_rdata;

  cache_dma_if dma_cmd ();

  cache_lookup lookup (
    .clk_i, .reset_i, .req_v_i, .req_op_i, .req_addr_i, .req_data_i, .ready_o,
    .advance_i(advance), .tl_v_o(tl_v), .tl_op_o(tl_op), .tl_addr_o(tl_addr),
    .tl_data_o(tl_data), .tag_rd_o(tag_rd), .valid_rd_o(valid_rd), .line_rd_o(line_rd),
    .st_we_i(st_we), .st_way_i(st_way), .st_addr_i(miss_addr),
    .st_mask_i(st_mask), .st_data_i(st_data),
    .tag_we_i(tag_we), .tag_way_i(tag_way), .tag_index_i(tag_index), .tag_i(tag_new),
    .dma_mem_v_i(mem_v), .dma_mem_we_i(mem_we), .dma_mem_way_i(mem_way),
    .dma_mem_addr_i(mem_addr), .dma_mem_wdata_i(mem_wdata), .dma_mem_rdata_o(mem_rdata)
  );

  cache_verify verify (
    .clk_i, .reset_i, .tl_v_i(tl_v), .tl_op_i(tl_op), .tl_addr_i(tl_addr),
    .tl_data_i(tl_data), .tag_rd_i(tag_rd), .valid_rd_i(valid_rd), .line_rd_i(line_rd),
    .advance_o(advance), .miss_o(miss), .miss_way_o(miss_way), .miss_dirty_o(miss_dirty),
    .victim_tag_o(victim_tag), .miss_addr_o(miss_addr), .miss_done_i(miss_done),
    .fill_word_i(dma_cmd.fill_word), .st_we_o(st_we), .st_way_o(st_way),
    .st_mask_o(st_mask), .st_data_o(st_data), .resp_v_o, .resp_data_o, .resp_yumi_i
  );

  cache_miss miss_handler (
    .clk_i, .reset_i, .miss_i(miss), .miss_way_i(miss_way), .miss_dirty_i(miss_dirty),
    .victim_tag_i(victim_tag), .miss_addr_i(miss_addr), .tag_we_o(tag_we),
    .tag_way_o(tag_way), .tag_index_o(tag_index), .tag_o(tag_new),
    .miss_done_o(miss_done), .dma(dma_cmd.miss)
  );

  cache_dma dma (
    .clk_i, .reset_i, .cmd(dma_cmd.dma), .offset_i(miss_addr[3:2]),
    .dma_pkt_v_o, .dma_pkt_write_o, .dma_pkt_addr_o, .dma_pkt_yumi_i,
    .dma_rdata_i, .dma_rdata_v_i, .dma_rdata_ready_o,
    .dma_wdata_o, .dma_wdata_v_o, .dma_wdata_yumi_i,
    .dma_mem_v_o(mem_v), .dma_mem_we_o(mem_we), .dma_mem_way_o(mem_way),
    .dma_mem_addr_o(mem_addr), .dma_mem_wdata_o(mem_wdata), .dma_mem_rdata_i(mem_rdata)
  );

endmodule

`default_nettype wire

//--- hdl/cache_verify.sv
// cache verify stage
// hit check, LRU and dirty state, load formatting and store merge

`default_nettype none

`include "cache_macros.svh"

module cache_verify (
  input  logic clk_i,
  input  logic reset_i,
  input  logic tl_v_i,
  input  cache_pkg::cache_op_e tl_op_i,
  input  cache_pkg::addr_t tl_addr_i,
  input  cache_pkg::data_t tl_data_i,
  input  cache_pkg::tag_t [1:0] tag_rd_i,
  input  logic [1:0] valid_rd_i,
  input  cache_pkg::data_t [1:0] line_rd_i,
  output logic advance_o,
  output logic miss_o,
  output logic miss_way_o,
  output logic miss_dirty_o,
  output cache_pkg::tag_t victim_tag_o,
  output cache_pkg::addr_t miss_addr_o,
  input  logic miss_done_i,
  input  cache_pkg::data_t fill_word_i,
  output logic st_we_o,
  output logic st_way_o,
  output cache_pkg::byte_mask_t st_mask_o,
  output cache_pkg::data_t st_data_o,
  output logic resp_v_o,
  output cache_pkg::data_t resp_data_o,
  input  logic resp_yumi_i
);

  logic v_r;
  logic filled_r;
  cache_pkg::cache_op_e op_r;
  cache_pkg::addr_t addr_r;
  cache_pkg::data_t data_r;
  cache_pkg::tag_t [1:0] tag_r;
  logic [1:0] valid_r;
  cache_pkg::data_t [1:0] line_r;
  logic [`CACHE_SETS-1:0] lru_r;
  logic [`CACHE_SETS-1:0] dirty_r [2];

  cache_pkg::index_t index;
  logic [1:0] hit;
  logic use_way;
  logic is_store;
  logic retire;
  cache_pkg::data_t word;
  logic [7:0] byte_sel;

  assign index = addr_r[4 +: $bits(cache_pkg::index_t)];
  assign hit[0] = valid_r[0] & (tag_r[0] == addr_r[15:8]);
  assign hit[1] = valid_r[1] & (tag_r[1] == addr_r[15:8]);
  assign is_store = (op_r == cache_pkg::OP_SW) | (op_r == cache_pkg::OP_SB);

  // an empty way first, otherwise the LRU one
  assign miss_way_o = ~valid_r[0] ? 1'b0 : (~valid_r[1] ? 1'b1 : lru_r[index]);
  assign miss_dirty_o = valid_r[miss_way_o] & dirty_r[miss_way_o][index];
  assign victim_tag_o = tag_r[miss_way_o];
  assign miss_addr_o = addr_r;

  assign miss_o = v_r & ~(|hit) & ~filled_r;
  assign resp_v_o = v_r & ((|hit) | filled_r);
  assign retire = resp_v_o & resp_yumi_i;
  assign use_way = filled_r ? miss_way_o : hit[1];

  // a retiring store leaves a bubble so the next read sees its write
  assign advance_o = ~v_r | (retire & ~is_store);

  assign word = filled_r ? fill_word_i : line_r[use_way];
  assign byte_sel = word[8*addr_r[1:0] +: 8];

  always_comb begin
    case (op_r)
      cache_pkg::OP_LW:  resp_data_o = word;
      cache_pkg::OP_LB:  resp_data_o = {{24{byte_sel[7]}}, byte_sel};
      cache_pkg::OP_LBU: resp_data_o = {24'b0, byte_sel};
      default:           resp_data_o = '0;
    endcase
  end

  assign st_we_o = retire & is_store;
  assign st_way_o = use_way;
  assign st_mask_o = (op_r == cache_pkg::OP_SW) ? 4'b1111 : (4'b0001 << addr_r[1:0]);
  assign st_data_o = (op_r == cache_pkg::OP_SW) ? data_r : {4{data_r[7:0]}};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_r <= 1'b0;
      filled_r <= 1'b0;
      lru_r <= '0;
      dirty_r[0] <= '0;
      dirty_r[1] <= '0;
    end else begin
      if (advance_o) begin
        v_r <= tl_v_i;
      end else if (retire) begin
        v_r <= 1'b0;
      end
      if (retire) begin
        filled_r <= 1'b0;
        lru_r[index] <= ~use_way;
        if (is_store) begin
          dirty_r[use_way][index] <= 1'b1;
        end
      end else if (miss_done_i) begin
        // refilled block starts clean
        filled_r <= 1'b1;
        dirty_r[miss_way_o][index] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance_o && tl_v_i) begin
      op_r <= tl_op_i;
      addr_r <= tl_addr_i;
      data_r <= tl_data_i;
      tag_r <= tag_rd_i;
      valid_r <= valid_rd_i;
      line_r <= line_rd_i;
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i) resp_yumi_i |-> resp_v_o);

endmodule

`default_nettype wire

//--- include/cache_macros.svh
// cache geometry
// widths and sizes shared by the packages and the RTL

`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// byte address width
`define CACHE_ADDR_WIDTH 16

// data word width
`define CACHE_DATA_WIDTH 32

// number of sets, two ways each
`define CACHE_SETS 16

// words per block
`define CACHE_BLOCK_WORDS 4

`endif
